// File: hw/jerry_pkg.sv
//**************************************************
// Jerry peripheral shared definitions: bus widths,
// register map and interrupt source positions
//**************************************************

package jerry_pkg;

	// Bus data and register width, one 16-bit word
	localparam int DATA_W = 16;

	// Word offset width on wb_adr, 16 register slots
	localparam int ADDR_W = 4;

	// Timer registers
	// Write loads the reload value, read returns the live down-count
	localparam logic [ADDR_W-1:0] REG_PIT1_PRE = ADDR_W'(0);
	localparam logic [ADDR_W-1:0] REG_PIT1_DIV = ADDR_W'(1);
	localparam logic [ADDR_W-1:0] REG_PIT2_PRE = ADDR_W'(2);
	localparam logic [ADDR_W-1:0] REG_PIT2_DIV = ADDR_W'(3);

	// Interrupt control register
	// Write: mask from low bits, pending bits cleared by ones in the upper field
	// Read: mask in low bits, pending flags in the upper field
	localparam logic [ADDR_W-1:0] REG_INT = ADDR_W'(4);

	// DAC holding registers, write only
	localparam logic [ADDR_W-1:0] REG_DAC_L = ADDR_W'(5);
	localparam logic [ADDR_W-1:0] REG_DAC_R = ADDR_W'(6);

	// Number of interrupt sources
	localparam int NUM_INT = 3;

	// Source positions within the mask and the pending field
	localparam int INT_TIMER1 = 0;
	localparam int INT_TIMER2 = 1;
	localparam int INT_EXT = 2;

	// Pending field starts at bit 8 of REG_INT
	localparam int INT_PEND_LSB = 8;

endpackage

// File: hw/jerry_io_bus.sv
//**************************************************
// Jerry I/O decoder, Wishbone classic slave with
// per-register write strobes and read-data select
//**************************************************
`timescale 1ns/1ps

module jerry_io_bus
	import jerry_pkg::*;
#(
	parameter int PIT_W = 16
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [ADDR_W-1:0] wb_adr,
	input  logic [PIT_W-1:0]  pit1_pre_count,
	input  logic [PIT_W-1:0]  pit1_div_count,
	input  logic [PIT_W-1:0]  pit2_pre_count,
	input  logic [PIT_W-1:0]  pit2_div_count,
	input  logic [DATA_W-1:0] int_status,
	output logic              wb_ack,
	output logic [DATA_W-1:0] wb_rdata,
	output logic              pit1_pre_w,
	output logic              pit1_div_w,
	output logic              pit2_pre_w,
	output logic              pit2_div_w,
	output logic              int_w,
	output logic              dac_l_w,
	output logic              dac_r_w
);

	// Request not yet acknowledged, accepted on this edge
	logic              req;
	logic              wr_req;
	logic [DATA_W-1:0] rd_next;

	// A held request is only taken once, ack blocks the repeat
	assign req = wb_cyc && wb_stb && !wb_ack;
	assign wr_req = req && wb_we;

	// One strobe per register, live for the single accept cycle
	assign pit1_pre_w = wr_req && (wb_adr == REG_PIT1_PRE);
	assign pit1_div_w = wr_req && (wb_adr == REG_PIT1_DIV);
	assign pit2_pre_w = wr_req && (wb_adr == REG_PIT2_PRE);
	assign pit2_div_w = wr_req && (wb_adr == REG_PIT2_DIV);
	assign int_w = wr_req && (wb_adr == REG_INT);
	assign dac_l_w = wr_req && (wb_adr == REG_DAC_L);
	assign dac_r_w = wr_req && (wb_adr == REG_DAC_R);

	// Read select
	// Counts are zero-extended when the timers are narrower than the bus
	always_comb begin
		case (wb_adr)
			REG_PIT1_PRE: rd_next = DATA_W'(pit1_pre_count);
			REG_PIT1_DIV: rd_next = DATA_W'(pit1_div_count);
			REG_PIT2_PRE: rd_next = DATA_W'(pit2_pre_count);
			REG_PIT2_DIV: rd_next = DATA_W'(pit2_div_count);
			REG_INT:      rd_next = int_status;
			// DAC registers are write only, unmapped slots also read zero
			default:      rd_next = '0;
		endcase
	end

	// Fixed one-cycle ack, every offset answers
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= req;
		end
	end

	// Read data captured with the ack so both are valid together
	always_ff @(posedge clk) begin
		if (req && !wb_we) begin
			wb_rdata <= rd_next;
		end
	end

endmodule

// File: hw/jerry_pit.sv
//**************************************************
// Programmable interval timer, prescaler and divider
// down counters producing a one-cycle tick
//**************************************************
`timescale 1ns/1ps

module jerry_pit
	import jerry_pkg::*;
#(
	parameter int PIT_W = 16
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              pre_w,
	input  logic              div_w,
	input  logic [DATA_W-1:0] wdata,
	output logic [PIT_W-1:0]  pre_count,
	output logic [PIT_W-1:0]  div_count,
	output logic              tick
);

	// Reload values as written over the bus
	logic [PIT_W-1:0] pre_reload;
	logic [PIT_W-1:0] div_reload;
	logic             running;
	logic             pre_wrap;
	logic             div_wrap;

	// Zero divider parks the timer
	assign running = (div_reload != '0);

	// Prescaler spans pre+1 clocks, divider spans div+1 prescaler wraps
	assign pre_wrap = (pre_count == '0);
	assign div_wrap = pre_wrap && (div_count == '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			pre_reload <= '0;
			div_reload <= '0;
			pre_count <= '0;
			div_count <= '0;
			tick <= 1'b0;
		end else begin
			tick <= 1'b0;
			if (pre_w) begin
				// Writing either register restarts both counters
				pre_reload <= wdata[PIT_W-1:0];
				pre_count <= wdata[PIT_W-1:0];
				div_count <= div_reload;
			end else if (div_w) begin
				div_reload <= wdata[PIT_W-1:0];
				div_count <= wdata[PIT_W-1:0];
				pre_count <= pre_reload;
			end else if (running) begin
				if (pre_wrap) begin
					pre_count <= pre_reload;
					if (div_wrap) begin
						div_count <= div_reload;
						// Registered pulse, same spacing as the wrap
						tick <= 1'b1;
					end else begin
						div_count <= div_count - 1'b1;
					end
				end else begin
					pre_count <= pre_count - 1'b1;
				end
			end
		end
	end

endmodule

// File: hw/jerry_int_ctrl.sv
//**************************************************
// Interrupt controller, enable mask and pending
// latches for two timers and one external line
//**************************************************
`timescale 1ns/1ps

module jerry_int_ctrl
	import jerry_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              int_w,
	input  logic [DATA_W-1:0] wdata,
	input  logic              tick1,
	input  logic              tick2,
	input  logic              eint,
	output logic [DATA_W-1:0] int_status,
	output logic              irq
);

	// Two-flop synchronizer plus one stage for edge detect
	logic               eint_s1;
	logic               eint_s2;
	logic               eint_d;
	logic               eint_rise;
	logic [NUM_INT-1:0] events;
	logic [NUM_INT-1:0] mask;
	logic [NUM_INT-1:0] pending;
	logic [NUM_INT-1:0] clr;

	assign eint_rise = eint_s2 && !eint_d;

	// Source vector in register bit order
	always_comb begin
		events = '0;
		events[INT_TIMER1] = tick1;
		events[INT_TIMER2] = tick2;
		events[INT_EXT] = eint_rise;
	end

	// Write-one-to-clear from the upper field of REG_INT
	assign clr = int_w ? wdata[INT_PEND_LSB +: NUM_INT] : '0;

	// Status word read back at REG_INT
	always_comb begin
		int_status = '0;
		int_status[NUM_INT-1:0] = mask;
		int_status[INT_PEND_LSB +: NUM_INT] = pending;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			eint_s1 <= 1'b0;
			eint_s2 <= 1'b0;
			eint_d <= 1'b0;
			mask <= '0;
			pending <= '0;
			irq <= 1'b0;
		end else begin
			eint_s1 <= eint;
			eint_s2 <= eint_s1;
			eint_d <= eint_s2;
			if (int_w) begin
				mask <= wdata[NUM_INT-1:0];
			end
			// Set is applied after the clear so a coincident event is kept
			pending <= (pending & ~clr) | (events & mask);
			// irq trails the pending bits by one clock
			irq <= |(pending & mask);
		end
	end

endmodule

// File: hw/jerry_dac.sv
//**************************************************
// Stereo DAC holding registers, new sample pair
// presented on each timer 1 tick
//**************************************************
`timescale 1ns/1ps

module jerry_dac
	import jerry_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              dac_l_w,
	input  logic              dac_r_w,
	input  logic [DATA_W-1:0] wdata,
	input  logic              tick,
	output logic [DATA_W-1:0] snd_l,
	output logic [DATA_W-1:0] snd_r,
	output logic              snd_valid
);

	// Samples waiting for the next tick
	logic [DATA_W-1:0] hold_l;
	logic [DATA_W-1:0] hold_r;

	always_ff @(posedge clk) begin
		if (rst) begin
			hold_l <= '0;
			hold_r <= '0;
			snd_l <= '0;
			snd_r <= '0;
			snd_valid <= 1'b0;
		end else begin
			if (dac_l_w) begin
				hold_l <= wdata;
			end
			if (dac_r_w) begin
				hold_r <= wdata;
			end
			// Both channels move together, sample rate set by timer 1
			if (tick) begin
				snd_l <= hold_l;
				snd_r <= hold_r;
			end
			snd_valid <= tick;
		end
	end

endmodule

// File: hw/jerry_periph.sv
//**************************************************
// Jerry peripheral top: bus decoder, two timers,
// interrupt controller and stereo DAC
//**************************************************
`timescale 1ns/1ps

module jerry_periph
	import jerry_pkg::*;
#(
	parameter int PIT_W = 16
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [ADDR_W-1:0] wb_adr,
	input  logic [DATA_W-1:0] wb_wdata,
	input  logic              eint,
	output logic              wb_ack,
	output logic [DATA_W-1:0] wb_rdata,
	output logic              irq,
	output logic [DATA_W-1:0] snd_l,
	output logic [DATA_W-1:0] snd_r,
	output logic              snd_valid
);

	// Register write strobes
	logic              pit1_pre_w;
	logic              pit1_div_w;
	logic              pit2_pre_w;
	logic              pit2_div_w;
	logic              int_w;
	logic              dac_l_w;
	logic              dac_r_w;
	// Timer state back to the read mux
	logic [PIT_W-1:0]  pit1_pre_count;
	logic [PIT_W-1:0]  pit1_div_count;
	logic [PIT_W-1:0]  pit2_pre_count;
	logic [PIT_W-1:0]  pit2_div_count;
	logic              tick1;
	logic              tick2;
	logic [DATA_W-1:0] int_status;

	jerry_io_bus #(.PIT_W(PIT_W)) io_bus_i (
		.clk(clk), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.pit1_pre_count(pit1_pre_count), .pit1_div_count(pit1_div_count),
		.pit2_pre_count(pit2_pre_count), .pit2_div_count(pit2_div_count),
		.int_status(int_status),
		.wb_ack(wb_ack), .wb_rdata(wb_rdata),
		.pit1_pre_w(pit1_pre_w), .pit1_div_w(pit1_div_w),
		.pit2_pre_w(pit2_pre_w), .pit2_div_w(pit2_div_w),
		.int_w(int_w), .dac_l_w(dac_l_w), .dac_r_w(dac_r_w)
	);

	// Timer 1 also paces the DAC
	jerry_pit #(.PIT_W(PIT_W)) pit1_i (
		.clk(clk), .rst(rst), .pre_w(pit1_pre_w), .div_w(pit1_div_w), .wdata(wb_wdata),
		.pre_count(pit1_pre_count), .div_count(pit1_div_count), .tick(tick1)
	);

	jerry_pit #(.PIT_W(PIT_W)) pit2_i (
		.clk(clk), .rst(rst), .pre_w(pit2_pre_w), .div_w(pit2_div_w), .wdata(wb_wdata),
		.pre_count(pit2_pre_count), .div_count(pit2_div_count), .tick(tick2)
	);

	jerry_int_ctrl int_ctrl_i (
		.clk(clk), .rst(rst), .int_w(int_w), .wdata(wb_wdata),
		.tick1(tick1), .tick2(tick2), .eint(eint),
		.int_status(int_status), .irq(irq)
	);

	jerry_dac dac_i (
		.clk(clk), .rst(rst), .dac_l_w(dac_l_w), .dac_r_w(dac_r_w), .wdata(wb_wdata),
		.tick(tick1), .snd_l(snd_l), .snd_r(snd_r), .snd_valid(snd_valid)
	);

endmodule

// File: tb/jerry_periph_chk.sv
//**************************************************
// Bus and output protocol assertions for the top
//**************************************************
`timescale 1ns/1ps

module jerry_periph_chk (
	input logic clk,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic irq,
	input logic snd_valid
);

	// Assertion failures so far, folded into the testbench error count
	int fail_count = 0;

	// Ack is a single-cycle pulse
	ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
		else begin
			$error("wb_ack high in two consecutive cycles");
			fail_count++;
		end

	// Ack only answers a request of the cycle before
	ack_after_req: assert property (@(posedge clk) disable iff (rst)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else begin
			$error("wb_ack without a preceding request");
			fail_count++;
		end

	// Outputs quiet under reset
	rst_quiet: assert property (@(posedge clk) rst |=> (!irq && !snd_valid))
		else begin
			$error("irq or snd_valid high during reset");
			fail_count++;
		end

	// One sample strobe per tick
	valid_pulse: assert property (@(posedge clk) disable iff (rst) snd_valid |=> !snd_valid)
		else begin
			$error("snd_valid longer than one cycle");
			fail_count++;
		end

endmodule

bind jerry_periph jerry_periph_chk chk_i (
	.clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
	.irq(irq), .snd_valid(snd_valid)
);

// File: tb/jerry_periph_tb.sv
//**************************************************
// Testbench for the Jerry peripheral top level
//**************************************************
`timescale 1ns/1ps

module jerry_periph_tb
	import jerry_pkg::*;
();

	localparam int PIT_W = 16;
	localparam int RESET_CYC = 5;
	// Edges per bus access including the leading drive edge
	localparam int BUS_CYC = 3;
	localparam int ACK_LIMIT = 8;
	// Longest timer period programmed here is (7+1)*(7+1)
	localparam int MAX_PERIOD = 64;
	// Worst case of each test in order with its timer windows
	localparam int TEST_CYC = (12 * BUS_CYC) + (5 * BUS_CYC + 9 * MAX_PERIOD + 32)
		+ (9 * BUS_CYC + 4 * MAX_PERIOD + 10) + (5 * BUS_CYC + 14)
		+ (6 * BUS_CYC + 2 * MAX_PERIOD + 16);
	localparam int WATCHDOG_CYC = RESET_CYC + TEST_CYC + 100;

	logic              clk;
	logic              rst;
	logic              wb_cyc;
	logic              wb_stb;
	logic              wb_we;
	logic [ADDR_W-1:0] wb_adr;
	logic [DATA_W-1:0] wb_wdata;
	logic              eint;
	logic              wb_ack;
	logic [DATA_W-1:0] wb_rdata;
	logic              irq;
	logic [DATA_W-1:0] snd_l;
	logic [DATA_W-1:0] snd_r;
	logic              snd_valid;
	string             cur_test;
	int                errors = 0;
	int                checks = 0;
	int                tests = 0;
	int                test_err = 0;

	jerry_periph #(.PIT_W(PIT_W)) dut_i (
		.clk(clk), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_wdata(wb_wdata), .eint(eint), .wb_ack(wb_ack), .wb_rdata(wb_rdata),
		.irq(irq), .snd_l(snd_l), .snd_r(snd_r), .snd_valid(snd_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("Timeout: tests still running after %0d cycles", WATCHDOG_CYC);
		$display("=== FAIL ===");
		$finish;
	end

	// REG_INT layout with the mask in bits 2..0 and the pending field in bits 10..8
	function automatic logic [DATA_W-1:0] int_word(input logic [2:0] mask, input logic [2:0] pend);
		return {5'b0, pend, 5'b0, mask};
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_err = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("%s finished, %0d errors", cur_test, errors - test_err);
	endtask

	// One Wishbone classic access with ack expected two edges after the drive
	task automatic bus_access(input logic we, input logic [ADDR_W-1:0] adr,
			input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
		int lat;
		lat = 0;
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_wdata <= wdata;
		do begin
			@(posedge clk);
			lat++;
		end while (!wb_ack && lat < ACK_LIMIT);
		if (!wb_ack) begin
			$display("%s: no ack from the DUT for offset %0d", cur_test, adr);
			errors++;
		end else begin
			check_value("ack latency", 2, lat);
		end
		rdata = wb_rdata;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] unused;
		bus_access(1'b1, adr, data, unused);
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] data);
		bus_access(1'b0, adr, '0, data);
	endtask

	task automatic read_check(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] exp,
			input string what);
		logic [DATA_W-1:0] data;
		bus_read(adr, data);
		check_value(what, exp, data);
	endtask

	// Edges until irq or snd_valid is seen high
	task automatic wait_high(input bit use_irq, input int limit, output int n);
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!(use_irq ? irq : snd_valid) && n < limit);
		if (!(use_irq ? irq : snd_valid)) begin
			$display("%s: %s stayed low for %0d cycles", cur_test,
				use_irq ? "irq" : "snd_valid", limit);
			errors++;
		end
	endtask

	task automatic reset_and_bus();
		start_test("reset_and_bus");
		for (int a = 0; a <= 6; a++) begin
			read_check(ADDR_W'(a), 16'h0000, "value after reset");
		end
		read_check(ADDR_W'(9), 16'h0000, "unmapped read");
		bus_write(REG_INT, int_word(3'b101, 3'b000));
		read_check(REG_INT, int_word(3'b101, 3'b000), "mask readback");
		bus_write(REG_INT, 16'h0000);
		end_test();
	endtask

	task automatic timer_period();
		int pre;
		int div;
		int n;
		int hits;
		start_test("timer_period");
		pre = $urandom_range(7, 0);
		div = $urandom_range(7, 1);
		bus_write(REG_DAC_L, 16'($urandom));
		bus_write(REG_DAC_R, 16'($urandom));
		bus_write(REG_PIT1_PRE, 16'(pre));
		bus_write(REG_PIT1_DIV, 16'(div));
		// First pulse only aligns the measurement
		wait_high(1'b0, MAX_PERIOD + 8, n);
		repeat (3) begin
			wait_high(1'b0, MAX_PERIOD + 8, n);
			check_value("snd_valid gap", (pre + 1) * (div + 1), n);
		end
		// Zero divider parks timer 1
		bus_write(REG_PIT1_DIV, 16'h0000);
		hits = 0;
		repeat (5 * MAX_PERIOD) begin
			@(posedge clk);
			if (snd_valid) begin
				hits++;
			end
		end
		check_value("snd_valid while stopped", 0, hits);
		end_test();
	endtask

	task automatic timer_interrupt();
		int n;
		int hits;
		start_test("timer_interrupt");
		bus_write(REG_PIT2_PRE, 16'($urandom_range(7, 0)));
		bus_write(REG_PIT2_DIV, 16'($urandom_range(7, 1)));
		bus_write(REG_INT, int_word(3'b010, 3'b000));
		wait_high(1'b1, MAX_PERIOD + 8, n);
		read_check(REG_INT, int_word(3'b010, 3'b010), "timer 2 pending");
		// Stop timer 2 so no fresh tick sets the bit again
		bus_write(REG_PIT2_DIV, 16'h0000);
		bus_write(REG_INT, int_word(3'b010, 3'b010));
		repeat (2) @(posedge clk);
		check_value("irq after clear", 0, irq);
		// Ticks of a masked source must not latch
		bus_write(REG_INT, int_word(3'b000, 3'b111));
		bus_write(REG_PIT2_DIV, 16'($urandom_range(7, 1)));
		hits = 0;
		repeat (3 * MAX_PERIOD) begin
			@(posedge clk);
			if (irq) begin
				hits++;
			end
		end
		check_value("irq while masked", 0, hits);
		read_check(REG_INT, 16'h0000, "pending while masked");
		bus_write(REG_PIT2_DIV, 16'h0000);
		end_test();
	endtask

	task automatic external_interrupt();
		int n;
		start_test("external_interrupt");
		bus_write(REG_INT, int_word(3'b100, 3'b111));
		eint <= 1'b1;
		wait_high(1'b1, 6, n);
		read_check(REG_INT, int_word(3'b100, 3'b100), "external pending");
		bus_write(REG_INT, int_word(3'b100, 3'b100));
		// Level held high gives no second edge
		repeat (8) @(posedge clk);
		check_value("irq with level held", 0, irq);
		read_check(REG_INT, int_word(3'b100, 3'b000), "pending with level held");
		eint <= 1'b0;
		bus_write(REG_INT, 16'h0000);
		end_test();
	endtask

	task automatic dac_transfer();
		int n;
		logic [DATA_W-1:0] old_l;
		logic [DATA_W-1:0] old_r;
		logic [DATA_W-1:0] new_l;
		logic [DATA_W-1:0] new_r;
		start_test("dac_transfer");
		new_l = 16'($urandom);
		new_r = 16'($urandom);
		// At least 20 clocks per period leaves room for both writes between ticks
		bus_write(REG_PIT1_PRE, 16'($urandom_range(7, 4)));
		bus_write(REG_PIT1_DIV, 16'($urandom_range(7, 3)));
		wait_high(1'b0, MAX_PERIOD + 8, n);
		old_l = snd_l;
		old_r = snd_r;
		bus_write(REG_DAC_L, new_l);
		bus_write(REG_DAC_R, new_r);
		n = 0;
		while (!snd_valid && n < MAX_PERIOD + 8) begin
			check_value("snd_l before transfer", old_l, snd_l);
			check_value("snd_r before transfer", old_r, snd_r);
			@(posedge clk);
			n++;
		end
		check_value("snd_valid after writes", 1, snd_valid);
		check_value("snd_l after transfer", new_l, snd_l);
		check_value("snd_r after transfer", new_r, snd_r);
		read_check(REG_DAC_L, 16'h0000, "DAC readback");
		bus_write(REG_PIT1_DIV, 16'h0000);
		end_test();
	endtask

	initial begin
		void'($urandom(32'h8052));
		rst <= 1'b1;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		wb_adr <= '0;
		wb_wdata <= '0;
		eint <= 1'b0;
		repeat (RESET_CYC) @(posedge clk);
		rst <= 1'b0;
		reset_and_bus();
		timer_period();
		timer_interrupt();
		external_interrupt();
		dac_transfer();
		// Protocol assertion failures count as errors too
		errors += dut_i.chk_i.fail_count;
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: jerry_periph.f
hw/jerry_pkg.sv
hw/jerry_io_bus.sv
hw/jerry_pit.sv
hw/jerry_int_ctrl.sv
hw/jerry_dac.sv
hw/jerry_periph.sv
tb/jerry_periph_chk.sv
tb/jerry_periph_tb.sv

// File: Makefile
# Verilator build and run for the Jerry peripheral testbench
# Override any variable on the command line, e.g. make run LOG=run.log

VERILATOR ?= verilator
TOP       ?= jerry_periph_tb
FILELIST  ?= jerry_periph.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= === PASS ===

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Pass or fail comes from the log, not from the simulator exit code
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
